//--- flist.f
source/radio_ctrl_pkg.sv
source/settings_port.sv
source/db_control.sv
source/fe_control.sv
source/fp_gpio_mux.sv
source/radio_io_core.sv
verification/radio_io_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the radio io core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module radio_io_core_tb \
   -Mdir obj_dir -o radio_io_core_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/radio_io_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qxF '** PASS **'; then
   exit 0
fi
echo "simulation did not report a pass"
exit 1

//--- source/db_control.sv
// daughterboard gpio, misc and led control
`timescale 1ns/1ns

module db_control (
   input  logic                                      radio_clk,
   input  logic                                      i_arst_n,
   input  logic                                      i_set_stb,
   input  logic                                      i_set_we,
   input  logic [7:0]                                i_set_addr,
   input  logic [radio_ctrl_pkg::REG_W-1:0]          i_set_data,
   input  logic [radio_ctrl_pkg::CHANS_PER_SLOT-1:0] i_run_rx,
   input  logic [radio_ctrl_pkg::CHANS_PER_SLOT-1:0] i_run_tx,
   input  logic [radio_ctrl_pkg::REG_W-1:0]          i_db_gpio_in,
   input  logic [radio_ctrl_pkg::REG_W-1:0]          i_fp_gpio_in,
   input  logic [radio_ctrl_pkg::REG_W-1:0]          i_misc_in,
   output logic [radio_ctrl_pkg::REG_W-1:0]          o_rb_data,
   output logic [radio_ctrl_pkg::REG_W-1:0]          o_db_gpio_out,
   output logic [radio_ctrl_pkg::REG_W-1:0]          o_db_gpio_ddr,
   output logic [radio_ctrl_pkg::REG_W-1:0]          o_fp_gpio_out,
   output logic [radio_ctrl_pkg::REG_W-1:0]          o_fp_gpio_ddr,
   output logic [radio_ctrl_pkg::REG_W-1:0]          o_misc_out,
   output logic [radio_ctrl_pkg::LED_W-1:0]          o_led
);
   import radio_ctrl_pkg::*;

   logic                run_rx;
   logic                run_tx;
   logic [1:0]          atr_sel;   // {tx, rx}
   logic                wr_hit;
   logic [DB_IDX_W-1:0] wr_idx;
   logic [DB_IDX_W-1:0] fp_sel;
   logic [REG_W-1:0]    db_regs [0:SR_FP_GPIO_DDR-SR_DB_BASE];   // atr words + ddr
   logic [REG_W-1:0]    misc_out_q;
   logic [REG_W-1:0]    misc_in_q;

   // either channel running counts for the whole slot
   assign run_rx  = |i_run_rx;
   assign run_tx  = |i_run_tx;
   assign atr_sel = {run_tx, run_rx};   // idle, rx, tx, fdx = register order

   assign wr_idx = DB_IDX_W'(i_set_addr - SR_DB_BASE);
   assign wr_hit = i_set_stb && i_set_we && (i_set_addr >= SR_DB_GPIO_IDLE)
                   && (i_set_addr <= SR_FP_GPIO_DDR);
   assign fp_sel = DB_IDX_W'(SR_FP_GPIO_IDLE - SR_DB_BASE) + DB_IDX_W'(atr_sel);

   // ------------------------------------------------
   // registers, atr outputs, misc stage, leds
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         for (int n = 0; n <= SR_FP_GPIO_DDR - SR_DB_BASE; n++)
            db_regs[n] <= '0;
         misc_out_q    <= '0;
         misc_in_q     <= '0;
         o_misc_out    <= '0;
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
         o_led         <= '0;
      end
      else
      begin
         if (wr_hit)
            db_regs[wr_idx] <= i_set_data;
         if (i_set_stb && i_set_we && i_set_addr == SR_MISC_OUT)
            misc_out_q <= i_set_data;
         o_misc_out <= misc_out_q;   // extra stage toward the board
         misc_in_q  <= i_misc_in;    // sampled before readback
         o_db_gpio_out <= db_regs[DB_IDX_W'(atr_sel)];
         o_db_gpio_ddr <= db_regs[DB_IDX_W'(SR_DB_GPIO_DDR - SR_DB_BASE)];   // no atr
         o_fp_gpio_out <= db_regs[fp_sel];
         o_fp_gpio_ddr <= db_regs[DB_IDX_W'(SR_FP_GPIO_DDR - SR_DB_BASE)];
         // rx port lit in full duplex, rx alone sits on tx/rx
         o_led <= {run_rx & run_tx, run_tx, run_rx & ~run_tx};
      end
   end

   // readback decode
   always_comb
   begin
      case (i_set_addr)
         RB_MISC_IN:    o_rb_data = misc_in_q;
         RB_DB_GPIO_IN: o_rb_data = i_db_gpio_in;
         RB_FP_GPIO_IN: o_rb_data = i_fp_gpio_in;
         RB_MISC_OUT:   o_rb_data = misc_out_q;
         default:       o_rb_data = '0;   // unmapped
      endcase
   end

endmodule

//--- source/fe_control.sv
// front-end i/q correction for one slot
`timescale 1ns/1ns

module fe_control (
   input  logic                              radio_clk,
   input  logic                              i_arst_n,
   input  logic                              i_set_stb,
   input  logic                              i_set_we,
   input  logic [7:0]                        i_set_addr,
   input  logic [radio_ctrl_pkg::REG_W-1:0]  i_set_data,
   input  logic                              i_rx_stb,
   input  radio_ctrl_pkg::sample_t           i_rx_data,
   input  radio_ctrl_pkg::sample_t           i_tx_data,
   output logic                              o_rx_stb,
   output radio_ctrl_pkg::sample_t           o_rx_data0,
   output radio_ctrl_pkg::sample_t           o_rx_data1,
   output radio_ctrl_pkg::sample_t           o_tx_data
);
   import radio_ctrl_pkg::*;

   logic [FE_CTRL_W-1:0] rx_ctrl [CHANS_PER_SLOT];   // one word per rx channel
   logic [FE_CTRL_W-1:0] tx_ctrl;

   // negate, full scale negative clips to max positive
   function automatic logic signed [15:0] neg_sat(input logic signed [15:0] x);
      return (x == 16'sh8000) ? 16'sh7fff : -x;
   endfunction

   // swap first, then the per-rail inversions
   function automatic sample_t fe_fix(input sample_t s, input logic [FE_CTRL_W-1:0] c);
      sample_t t;
      t = s;
      if (c[FE_SWAP_BIT])
      begin
         t.iq.i = s.iq.q;
         t.iq.q = s.iq.i;
      end
      if (c[FE_INV_I_BIT])
         t.iq.i = neg_sat(t.iq.i);
      if (c[FE_INV_Q_BIT])
         t.iq.q = neg_sat(t.iq.q);
      return t;
   endfunction

   // ------------------------------------------------
   // control words
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         for (int n = 0; n < CHANS_PER_SLOT; n++)
            rx_ctrl[n] <= '0;
         tx_ctrl  <= '0;
         o_rx_stb <= 1'b0;
      end
      else
      begin
         if (i_set_stb && i_set_we)
         begin
            for (int n = 0; n < CHANS_PER_SLOT; n++)
               if (i_set_addr == 8'(SR_RX_FE_BASE + n * SR_FE_CHAN_OFFSET))
                  rx_ctrl[n] <= i_set_data[FE_CTRL_W-1:0];
            if (i_set_addr == SR_TX_FE_BASE)
               tx_ctrl <= i_set_data[FE_CTRL_W-1:0];
         end
         o_rx_stb <= i_rx_stb;   // follows data by one edge
      end
   end

   // sample path, both rx channels see the same adc word
   always_ff @(posedge radio_clk)
   begin
      if (i_rx_stb)
      begin
         o_rx_data0 <= fe_fix(i_rx_data, rx_ctrl[0]);
         o_rx_data1 <= fe_fix(i_rx_data, rx_ctrl[1]);
      end
      o_tx_data <= fe_fix(i_tx_data, tx_ctrl);   // dac runs every cycle
   end

endmodule

//--- source/fp_gpio_mux.sv
// front-panel gpio slot select
`timescale 1ns/1ns

module fp_gpio_mux (
   input  logic                                radio_clk,
   input  logic                                i_arst_n,
   input  logic                                i_set_stb,
   input  logic                                i_set_we,
   input  logic [7:0]                          i_set_addr,
   input  logic [radio_ctrl_pkg::REG_W-1:0]    i_set_data,
   input  logic [radio_ctrl_pkg::REG_W-1:0]    i_fp_out0,
   input  logic [radio_ctrl_pkg::REG_W-1:0]    i_fp_ddr0,
   input  logic [radio_ctrl_pkg::REG_W-1:0]    i_fp_out1,
   input  logic [radio_ctrl_pkg::REG_W-1:0]    i_fp_ddr1,
   output logic [radio_ctrl_pkg::FP_GPIO_W-1:0] o_fp_gpio_out,
   output logic [radio_ctrl_pkg::FP_GPIO_W-1:0] o_fp_gpio_ddr
);
   import radio_ctrl_pkg::*;

   logic [2*FP_GPIO_W-1:0] src_q;   // two bits per pin, 0 = slot 0

   // ------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         src_q         <= '0;   // everything from slot 0
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end
      else
      begin
         if (i_set_stb && i_set_we && i_set_addr == SR_FP_GPIO_SRC)
            src_q <= i_set_data[2*FP_GPIO_W-1:0];
         for (int p = 0; p < FP_GPIO_W; p++)
         begin
            // any nonzero field means slot 1
            o_fp_gpio_out[p] <= (src_q[2*p +: 2] == 2'd0) ? i_fp_out0[p] : i_fp_out1[p];
            o_fp_gpio_ddr[p] <= (src_q[2*p +: 2] == 2'd0) ? i_fp_ddr0[p] : i_fp_ddr1[p];
         end
      end
   end

endmodule

//--- source/radio_ctrl_pkg.sv
// radio control shared definitions
package radio_ctrl_pkg;

   // ------------------------------------------------
   // sizes
   localparam int NUM_SLOTS      = 2;
   localparam int NUM_CHANNELS   = 4;    // rx channels over both slots
   localparam int CHANS_PER_SLOT = 2;
   localparam int SET_ADDR_W     = 9;    // msb picks the slot
   localparam int REG_W          = 32;
   localparam int FP_GPIO_W      = 12;
   localparam int LED_W          = 3;
   localparam int DB_IDX_W       = 4;    // index into the atr word bank
   localparam int FE_CTRL_W      = 3;

   // ------------------------------------------------
   // write side register map, 8 bit slot-local
   localparam logic [7:0] SR_DB_BASE        = 8'd160;
   localparam logic [7:0] SR_DB_GPIO_IDLE   = SR_DB_BASE + 8'd0;
   localparam logic [7:0] SR_DB_GPIO_RX     = SR_DB_BASE + 8'd1;
   localparam logic [7:0] SR_DB_GPIO_TX     = SR_DB_BASE + 8'd2;
   localparam logic [7:0] SR_DB_GPIO_FDX    = SR_DB_BASE + 8'd3;
   localparam logic [7:0] SR_DB_GPIO_DDR    = SR_DB_BASE + 8'd4;
   localparam logic [7:0] SR_FP_GPIO_IDLE   = SR_DB_BASE + 8'd5;
   localparam logic [7:0] SR_FP_GPIO_RX     = SR_DB_BASE + 8'd6;
   localparam logic [7:0] SR_FP_GPIO_TX     = SR_DB_BASE + 8'd7;
   localparam logic [7:0] SR_FP_GPIO_FDX    = SR_DB_BASE + 8'd8;
   localparam logic [7:0] SR_FP_GPIO_DDR    = SR_DB_BASE + 8'd9;
   localparam logic [7:0] SR_MISC_OUT       = SR_DB_BASE + 8'd10;
   localparam logic [7:0] SR_TX_FE_BASE     = SR_DB_BASE + 8'd48;
   localparam logic [7:0] SR_RX_FE_BASE     = SR_DB_BASE + 8'd64;
   localparam logic [7:0] SR_FE_CHAN_OFFSET = 8'd16;
   localparam logic [7:0] SR_FP_GPIO_SRC    = 8'd150;   // slot 0 only

   // readback map
   localparam logic [7:0] RB_DB_BASE    = 8'd16;
   localparam logic [7:0] RB_MISC_IN    = RB_DB_BASE + 8'd0;
   localparam logic [7:0] RB_DB_GPIO_IN = RB_DB_BASE + 8'd1;
   localparam logic [7:0] RB_FP_GPIO_IN = RB_DB_BASE + 8'd2;
   localparam logic [7:0] RB_MISC_OUT   = RB_DB_BASE + 8'd3;

   // front-end control word bits
   localparam int FE_SWAP_BIT  = 0;
   localparam int FE_INV_I_BIT = 1;
   localparam int FE_INV_Q_BIT = 2;

   typedef struct packed {
      logic signed [15:0] i;   // upper half
      logic signed [15:0] q;
   } iq_pair_t;

   // one adc/dac word, raw or as i/q
   typedef union packed {
      logic [31:0] raw;
      iq_pair_t    iq;
   } sample_t;

endpackage

//--- source/radio_io_core.sv
// radio clock io core, two slots
`timescale 1ns/1ns

module radio_io_core (
   input  logic                                           radio_clk,
   input  logic                                           i_arst_n,
   // settings
   input  logic                                           i_set_req,
   input  logic                                           i_set_we,
   input  logic [radio_ctrl_pkg::SET_ADDR_W-1:0]          i_set_addr,
   input  logic [radio_ctrl_pkg::REG_W-1:0]               i_set_data,
   output logic                                           o_set_ack,
   output logic [radio_ctrl_pkg::REG_W-1:0]               o_rb_data,
   // receive
   input  radio_ctrl_pkg::sample_t                        i_rx0,
   input  radio_ctrl_pkg::sample_t                        i_rx1,
   input  logic [radio_ctrl_pkg::NUM_SLOTS-1:0]           i_rx_stb,
   output radio_ctrl_pkg::sample_t [radio_ctrl_pkg::NUM_CHANNELS-1:0] o_rx_data,
   output logic [radio_ctrl_pkg::NUM_SLOTS-1:0]           o_rx_stb,
   // transmit
   input  radio_ctrl_pkg::sample_t [radio_ctrl_pkg::NUM_SLOTS-1:0] i_tx_data,
   output radio_ctrl_pkg::sample_t                        o_tx0,
   output radio_ctrl_pkg::sample_t                        o_tx1,
   // run state per channel
   input  logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]        i_rx_running,
   input  logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]        i_tx_running,
   // daughterboard gpio
   input  logic [radio_ctrl_pkg::REG_W-1:0]               i_db0_gpio_in,
   input  logic [radio_ctrl_pkg::REG_W-1:0]               i_db1_gpio_in,
   output logic [radio_ctrl_pkg::REG_W-1:0]               o_db0_gpio_out,
   output logic [radio_ctrl_pkg::REG_W-1:0]               o_db0_gpio_ddr,
   output logic [radio_ctrl_pkg::REG_W-1:0]               o_db1_gpio_out,
   output logic [radio_ctrl_pkg::REG_W-1:0]               o_db1_gpio_ddr,
   // front panel
   input  logic [radio_ctrl_pkg::REG_W-1:0]               i_fp_gpio_in,
   output logic [radio_ctrl_pkg::FP_GPIO_W-1:0]           o_fp_gpio_out,
   output logic [radio_ctrl_pkg::FP_GPIO_W-1:0]           o_fp_gpio_ddr,
   // leds, {rx, txrx_tx, txrx_rx}
   output logic [radio_ctrl_pkg::LED_W-1:0]               o_radio_led0,
   output logic [radio_ctrl_pkg::LED_W-1:0]               o_radio_led1,
   // misc
   input  logic [radio_ctrl_pkg::REG_W-1:0]               i_radio0_misc_in,
   input  logic [radio_ctrl_pkg::REG_W-1:0]               i_radio1_misc_in,
   output logic [radio_ctrl_pkg::REG_W-1:0]               o_radio0_misc_out,
   output logic [radio_ctrl_pkg::REG_W-1:0]               o_radio1_misc_out
);
   import radio_ctrl_pkg::*;

   logic [NUM_SLOTS-1:0] slot_stb;   // one strobe per slot
   logic                 slot_we;
   logic [7:0]           slot_addr;
   logic [REG_W-1:0]     slot_data;
   logic [REG_W-1:0]     rb_data0, rb_data1;
   logic [REG_W-1:0]     fp_out0, fp_ddr0, fp_out1, fp_ddr1;

   // ------------------------------------------------
   // settings
   settings_port settings_port_inst (
      .radio_clk, .i_arst_n, .i_set_req, .i_set_we, .i_set_addr, .i_set_data,
      .i_rb_data0(rb_data0), .i_rb_data1(rb_data1), .o_set_ack, .o_rb_data,
      .o_slot_stb(slot_stb), .o_slot_we(slot_we), .o_slot_addr(slot_addr),
      .o_slot_data(slot_data)
   );

   // ------------------------------------------------
   // slot 0, channels 0 and 1
   db_control db_control0_inst (
      .radio_clk, .i_arst_n, .i_set_stb(slot_stb[0]), .i_set_we(slot_we),
      .i_set_addr(slot_addr), .i_set_data(slot_data),
      .i_run_rx(i_rx_running[1:0]), .i_run_tx(i_tx_running[1:0]),
      .i_db_gpio_in(i_db0_gpio_in), .i_fp_gpio_in(i_fp_gpio_in), .i_misc_in(i_radio0_misc_in),
      .o_rb_data(rb_data0), .o_db_gpio_out(o_db0_gpio_out), .o_db_gpio_ddr(o_db0_gpio_ddr),
      .o_fp_gpio_out(fp_out0), .o_fp_gpio_ddr(fp_ddr0), .o_misc_out(o_radio0_misc_out),
      .o_led(o_radio_led0)
   );

   fe_control fe_control0_inst (
      .radio_clk, .i_arst_n, .i_set_stb(slot_stb[0]), .i_set_we(slot_we),
      .i_set_addr(slot_addr), .i_set_data(slot_data),
      .i_rx_stb(i_rx_stb[0]), .i_rx_data(i_rx0), .i_tx_data(i_tx_data[0]),
      .o_rx_stb(o_rx_stb[0]), .o_rx_data0(o_rx_data[0]), .o_rx_data1(o_rx_data[1]),
      .o_tx_data(o_tx0)
   );

   // slot 1, channels 2 and 3
   db_control db_control1_inst (
      .radio_clk, .i_arst_n, .i_set_stb(slot_stb[1]), .i_set_we(slot_we),
      .i_set_addr(slot_addr), .i_set_data(slot_data),
      .i_run_rx(i_rx_running[3:2]), .i_run_tx(i_tx_running[3:2]),
      .i_db_gpio_in(i_db1_gpio_in), .i_fp_gpio_in(i_fp_gpio_in), .i_misc_in(i_radio1_misc_in),
      .o_rb_data(rb_data1), .o_db_gpio_out(o_db1_gpio_out), .o_db_gpio_ddr(o_db1_gpio_ddr),
      .o_fp_gpio_out(fp_out1), .o_fp_gpio_ddr(fp_ddr1), .o_misc_out(o_radio1_misc_out),
      .o_led(o_radio_led1)
   );

   fe_control fe_control1_inst (
      .radio_clk, .i_arst_n, .i_set_stb(slot_stb[1]), .i_set_we(slot_we),
      .i_set_addr(slot_addr), .i_set_data(slot_data),
      .i_rx_stb(i_rx_stb[1]), .i_rx_data(i_rx1), .i_tx_data(i_tx_data[1]),
      .o_rx_stb(o_rx_stb[1]), .o_rx_data0(o_rx_data[2]), .o_rx_data1(o_rx_data[3]),
      .o_tx_data(o_tx1)
   );

   // front panel pins, source register written through slot 0
   fp_gpio_mux fp_gpio_mux_inst (
      .radio_clk, .i_arst_n, .i_set_stb(slot_stb[0]), .i_set_we(slot_we),
      .i_set_addr(slot_addr), .i_set_data(slot_data),
      .i_fp_out0(fp_out0), .i_fp_ddr0(fp_ddr0), .i_fp_out1(fp_out1), .i_fp_ddr1(fp_ddr1),
      .o_fp_gpio_out, .o_fp_gpio_ddr
   );

endmodule

//--- source/settings_port.sv
// settings request port and slot steering
`timescale 1ns/1ns

module settings_port (
   input  logic                                    radio_clk,
   input  logic                                    i_arst_n,
   input  logic                                    i_set_req,
   input  logic                                    i_set_we,
   input  logic [radio_ctrl_pkg::SET_ADDR_W-1:0]   i_set_addr,
   input  logic [radio_ctrl_pkg::REG_W-1:0]        i_set_data,
   input  logic [radio_ctrl_pkg::REG_W-1:0]        i_rb_data0,
   input  logic [radio_ctrl_pkg::REG_W-1:0]        i_rb_data1,
   output logic                                    o_set_ack,
   output logic [radio_ctrl_pkg::REG_W-1:0]        o_rb_data,
   output logic [radio_ctrl_pkg::NUM_SLOTS-1:0]    o_slot_stb,
   output logic                                    o_slot_we,
   output logic [7:0]                              o_slot_addr,
   output logic [radio_ctrl_pkg::REG_W-1:0]        o_slot_data
);
   import radio_ctrl_pkg::*;

   logic take_req;   // idle and master asking

   // idle means no strobe out and ack low
   assign take_req = i_set_req && !o_set_ack && !(|o_slot_stb);

   // ------------------------------------------------
   // handshake fsm, state lives in stb and ack
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         o_slot_stb <= '0;
         o_set_ack  <= 1'b0;
      end
      else if (|o_slot_stb)
      begin
         o_slot_stb <= '0;     // single cycle strobe
         o_set_ack  <= 1'b1;   // slot acted on this edge
      end
      else if (o_set_ack)
      begin
         if (!i_set_req)
            o_set_ack <= 1'b0;
      end
      else if (i_set_req)
         o_slot_stb <= NUM_SLOTS'(1) << i_set_addr[SET_ADDR_W-1];
   end

   // request fields and readback word
   always_ff @(posedge radio_clk)
   begin
      if (take_req)
      begin
         o_slot_we   <= i_set_we;
         o_slot_addr <= i_set_addr[SET_ADDR_W-2:0];
         o_slot_data <= i_set_data;
      end
      if (|o_slot_stb)
         o_rb_data <= o_slot_stb[1] ? i_rb_data1 : i_rb_data0;   // held while ack
   end

endmodule

//--- verification/radio_io_core_tb.sv
// radio io core testbench
`timescale 1ns/1ns

module radio_io_core_tb;
   import radio_ctrl_pkg::*;

   localparam int          ACK_LIMIT = 16;   // cycles allowed per handshake phase
   localparam logic [31:0] OP_WRITE  = "w";
   localparam logic [31:0] OP_READ   = "r";
   localparam logic [31:0] OP_INPUT  = "i";
   localparam logic [31:0] OP_CHECK  = "c";
   localparam logic [31:0] OP_NOTE   = "#";

   logic                       radio_clk;
   logic                       arst_n;
   logic                       set_req;
   logic                       set_we;
   logic [SET_ADDR_W-1:0]      set_addr;
   logic [REG_W-1:0]           set_data;
   logic                       set_ack;
   logic [REG_W-1:0]           rb_data;
   sample_t                    rx0;
   sample_t                    rx1;
   logic [NUM_SLOTS-1:0]       rx_stb_in;
   sample_t [NUM_CHANNELS-1:0] rx_data;
   logic [NUM_SLOTS-1:0]       rx_stb_out;
   sample_t [NUM_SLOTS-1:0]    tx_data;
   sample_t                    tx0;
   sample_t                    tx1;
   logic [NUM_CHANNELS-1:0]    rx_running;
   logic [NUM_CHANNELS-1:0]    tx_running;
   logic [REG_W-1:0]           db0_gpio_in;
   logic [REG_W-1:0]           db1_gpio_in;
   logic [REG_W-1:0]           db0_gpio_out;
   logic [REG_W-1:0]           db0_gpio_ddr;
   logic [REG_W-1:0]           db1_gpio_out;
   logic [REG_W-1:0]           db1_gpio_ddr;
   logic [REG_W-1:0]           fp_gpio_in;
   logic [FP_GPIO_W-1:0]       fp_gpio_out;
   logic [FP_GPIO_W-1:0]       fp_gpio_ddr;
   logic [LED_W-1:0]           radio_led0;
   logic [LED_W-1:0]           radio_led1;
   logic [REG_W-1:0]           radio0_misc_in;
   logic [REG_W-1:0]           radio1_misc_in;
   logic [REG_W-1:0]           radio0_misc_out;
   logic [REG_W-1:0]           radio1_misc_out;

   // records from the data file
   logic [31:0]     op_q[$];
   logic [31:0]     a_q[$];
   logic [31:0]     b_q[$];
   logic [31:0]     exp_q[$];
   logic [8*32-1:0] name_q[$];
   int              n_rec = 0;
   int              checks = 0;
   int              value_errors = 0;
   int              other_errors = 0;

   radio_io_core radio_io_core_inst (
      .radio_clk(radio_clk), .i_arst_n(arst_n),
      .i_set_req(set_req), .i_set_we(set_we), .i_set_addr(set_addr), .i_set_data(set_data),
      .o_set_ack(set_ack), .o_rb_data(rb_data),
      .i_rx0(rx0), .i_rx1(rx1), .i_rx_stb(rx_stb_in), .o_rx_data(rx_data),
      .o_rx_stb(rx_stb_out),
      .i_tx_data(tx_data), .o_tx0(tx0), .o_tx1(tx1),
      .i_rx_running(rx_running), .i_tx_running(tx_running),
      .i_db0_gpio_in(db0_gpio_in), .i_db1_gpio_in(db1_gpio_in),
      .o_db0_gpio_out(db0_gpio_out), .o_db0_gpio_ddr(db0_gpio_ddr),
      .o_db1_gpio_out(db1_gpio_out), .o_db1_gpio_ddr(db1_gpio_ddr),
      .i_fp_gpio_in(fp_gpio_in), .o_fp_gpio_out(fp_gpio_out), .o_fp_gpio_ddr(fp_gpio_ddr),
      .o_radio_led0(radio_led0), .o_radio_led1(radio_led1),
      .i_radio0_misc_in(radio0_misc_in), .i_radio1_misc_in(radio1_misc_in),
      .o_radio0_misc_out(radio0_misc_out), .o_radio1_misc_out(radio1_misc_out)
   );

   initial
   begin
      radio_clk = 1'b0;
      forever #4 radio_clk = ~radio_clk;   // 8 ns period
   end

   // --------------------------------------------------
   // file loading and checking helpers
   task automatic load_records();
      int               fd;
      int               code;
      logic [31:0]      op;
      logic [31:0]      a;
      logic [31:0]      b;
      logic [31:0]      e;
      logic [8*32-1:0]  nm;
      logic [8*128-1:0] line;
      fd = $fopen("verification/radio_io_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the test data file");
         other_errors++;
         return;
      end
      while (!$feof(fd))
      begin
         code = $fscanf(fd, "%s", op);
         if (code != 1)
            break;
         if (op == OP_NOTE)
            code = $fgets(line, fd);   // skip column notes
         else
         begin
            code = $fscanf(fd, "%h %h %h %s", a, b, e, nm);
            if (code != 4)
            begin
               $display("malformed record after %0d good ones", op_q.size());
               other_errors++;
               break;
            end
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
            exp_q.push_back(e);
            name_q.push_back(nm);
         end
      end
      $fclose(fd);
      n_rec = op_q.size();
   endtask

   task automatic check_value(input string tname, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("Fail %s expected %h actual %h", tname, expected, actual);
         value_errors++;
      end
   endtask

   // four-phase request, waits on ack both ways
   task automatic settings_access(input logic we, input logic [31:0] addr,
                                  input logic [31:0] data, output logic [31:0] rb);
      int n;
      @(negedge radio_clk);
      set_we   = we;
      set_addr = addr[SET_ADDR_W-1:0];
      set_data = data;
      set_req  = 1'b1;
      n = 0;
      while (!set_ack && n < ACK_LIMIT)
      begin
         @(negedge radio_clk);
         n++;
      end
      if (!set_ack)
      begin
         $display("settings request to address %h was never acknowledged", addr);
         other_errors++;
      end
      rb      = rb_data;   // valid while ack high
      set_req = 1'b0;
      n = 0;
      while (set_ack && n < ACK_LIMIT)
      begin
         @(negedge radio_clk);
         n++;
      end
      if (set_ack)
      begin
         $display("ack stayed high after request to address %h was dropped", addr);
         other_errors++;
      end
   endtask

   task automatic drive_input(input logic [31:0] sel, input logic [31:0] val);
      @(negedge radio_clk);
      case (sel)
         0:  rx_running = val[NUM_CHANNELS-1:0];
         1:  tx_running = val[NUM_CHANNELS-1:0];
         2:  db0_gpio_in = val;
         3:  db1_gpio_in = val;
         4:  fp_gpio_in = val;
         5:  radio0_misc_in = val;
         6:  radio1_misc_in = val;
         7, 8:
         begin
            if (sel == 7)
               rx0.raw = val;
            else
               rx1.raw = val;
            rx_stb_in[sel-7] = 1'b1;   // one cycle strobe
            @(negedge radio_clk);
            rx_stb_in = '0;
         end
         9:  tx_data[0].raw = val;
         10: tx_data[1].raw = val;
         default:
         begin
            $display("unknown input selector %0d in test data", sel);
            other_errors++;
         end
      endcase
   endtask

   function automatic logic [31:0] output_word(input logic [31:0] sel);
      case (sel)
         0:  return db0_gpio_out;
         1:  return db0_gpio_ddr;
         2:  return db1_gpio_out;
         3:  return db1_gpio_ddr;
         4:  return 32'(fp_gpio_out);
         5:  return 32'(fp_gpio_ddr);
         6:  return radio0_misc_out;
         7:  return radio1_misc_out;
         8:  return 32'(radio_led0);
         9:  return 32'(radio_led1);
         10: return rx_data[0].raw;
         11: return rx_data[1].raw;
         12: return rx_data[2].raw;
         13: return rx_data[3].raw;
         14: return tx0.raw;
         15: return tx1.raw;
         16: return 32'(set_ack);
         17: return 32'(rx_stb_out);
         default:
         begin
            $display("unknown output selector %0d in test data", sel);
            other_errors++;
            return '0;
         end
      endcase
   endfunction

   // every output with a reset value starts at zero
   task automatic check_reset_state();
      for (int s = 0; s < 18; s++)
         if (s < 10 || s > 15)   // sample words carry no reset
            check_value($sformatf("rst_sel_%0d", s), 32'd0, output_word(s));
   endtask

   task automatic run_record(input int k);
      logic [31:0] rb;
      case (op_q[k])
         OP_WRITE:
            settings_access(1'b1, a_q[k], b_q[k], rb);
         OP_READ:
         begin
            settings_access(1'b0, a_q[k], '0, rb);
            check_value(string'(name_q[k]), exp_q[k], rb);
         end
         OP_INPUT:
            drive_input(a_q[k], b_q[k]);
         OP_CHECK:
         begin
            repeat (b_q[k]) @(negedge radio_clk);   // pipeline edges to wait
            check_value(string'(name_q[k]), exp_q[k], output_word(a_q[k]));
         end
         default:
         begin
            $display("record %0d has an unknown operation code", k);
            other_errors++;
         end
      endcase
   endtask

   // --------------------------------------------------
   // main sequence
   initial
   begin
      arst_n         = 1'b0;
      set_req        = 1'b0;
      set_we         = 1'b0;
      set_addr       = '0;
      set_data       = '0;
      rx0            = '0;
      rx1            = '0;
      rx_stb_in      = '0;
      tx_data        = '0;
      rx_running     = '0;
      tx_running     = '0;
      db0_gpio_in    = '0;
      db1_gpio_in    = '0;
      fp_gpio_in     = '0;
      radio0_misc_in = '0;
      radio1_misc_in = '0;
      load_records();
      repeat (5) @(posedge radio_clk);
      @(negedge radio_clk);
      arst_n = 1'b1;
      check_reset_state();
      if (n_rec == 0)
      begin
         $display("no test records were read");
         other_errors++;
      end
      for (int k = 0; k < n_rec; k++)
         run_record(k);
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // watchdog, 40 cycles per record
   initial
   begin
      wait (n_rec > 0);
      repeat (n_rec * 40) @(posedge radio_clk);
      $display("watchdog expired before all test records were processed");
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- verification/radio_io_testdata.txt
# op a b expected name, numbers in hex
# w addr data, r addr - expected, i input_sel value, c output_sel wait_edges expected
c 0 0 00000000 rst_db0_out
c 3 0 00000000 rst_db1_ddr
c 4 0 00000000 rst_fp_out
c 5 0 00000000 rst_fp_ddr
c 7 0 00000000 rst_misc1_out
c 9 0 00000000 rst_led1
c 10 0 00000000 rst_ack
i 5 a5a50001 0 misc0_in
i 6 5a5a0002 0 misc1_in
i 2 00c0ffee 0 db0_gpio_in
i 3 0000beef 0 db1_gpio_in
i 4 00000fed 0 fp_gpio_in
r 010 0 a5a50001 rb_misc_in_s0
r 110 0 5a5a0002 rb_misc_in_s1
r 011 0 00c0ffee rb_db_in_s0
r 111 0 0000beef rb_db_in_s1
r 012 0 00000fed rb_fp_in_s0
r 112 0 00000fed rb_fp_in_s1
w 0aa 12345678 0 misc0_write
c 6 0 12345678 misc0_pin
c 7 0 00000000 misc1_pin_indep
w 1aa 87654321 0 misc1_write
c 7 0 87654321 misc1_pin
r 013 0 12345678 rb_misc_out_s0
r 113 0 87654321 rb_misc_out_s1
r 014 0 00000000 rb_unmapped
r 0a0 0 00000000 rb_write_only
w 0a0 11110000 0 atr_idle_word
w 0a1 22220001 0 atr_rx_word
w 0a2 33330002 0 atr_tx_word
w 0a3 44440003 0 atr_fdx_word
w 0a4 0000ffff 0 atr_ddr_word
c 0 1 11110000 atr_idle
c 1 0 0000ffff atr_ddr
i 0 1 0 rx_ch0_on
c 0 1 22220001 atr_rx_ch0
c 8 0 00000001 led0_rx
i 0 2 0 rx_ch1_only
c 0 1 22220001 atr_rx_ch1
i 1 2 0 tx_ch1_on
c 0 1 44440003 atr_fdx
c 8 0 00000006 led0_fdx
i 0 0 0 rx_off
c 0 1 33330002 atr_tx
c 8 0 00000002 led0_tx
i 1 0 0 tx_off
c 0 1 11110000 atr_idle_again
c 8 0 00000000 led0_idle
i 0 4 0 rx_ch2_on
c 9 1 00000001 led1_rx
c 8 0 00000000 led0_unaffected
i 1 8 0 tx_ch3_on
c 9 1 00000006 led1_fdx
i 0 0 0 rx_slot1_off
c 9 1 00000002 led1_tx
i 1 0 0 tx_slot1_off
c 9 1 00000000 led1_idle
w 0e0 1 0 fe_rx0_swap
w 0f0 6 0 fe_rx1_invert
i 7 12348000 0 rx0_sample
c a 0 80001234 rx_ch0_swap
c b 0 edcc7fff rx_ch1_inv_sat
c 11 0 00000001 rx_stb_slot0
c 11 1 00000000 rx_stb_clear
w 0e0 3 0 fe_rx0_swap_inv
i 7 12348000 0 rx0_sample_2
c a 0 7fff1234 rx_ch0_swap_inv
w 1e0 4 0 fe_rx2_inv_q
i 8 0001fffe 0 rx1_sample
c c 0 00010002 rx_ch2_inv_q
c d 0 0001fffe rx_ch3_plain
c 11 0 00000002 rx_stb_slot1
w 0d0 7 0 fe_tx0_all
i 9 80000005 0 tx0_sample
c e 1 fffb7fff tx0_corrected
i a 01020304 0 tx1_sample
c f 1 01020304 tx1_plain
w 1d0 2 0 fe_tx1_inv_i
c f 0 fefe0304 tx1_inv_i
w 0a5 00000aaa 0 fp0_idle_word
w 0a9 00000f0f 0 fp0_ddr_word
w 1a5 00000555 0 fp1_idle_word
w 1a9 000000f0 0 fp1_ddr_word
c 4 2 00000aaa fp_out_slot0
c 5 0 00000f0f fp_ddr_slot0
w 096 00000039 0 fp_src_low
c 4 1 00000aad fp_out_mixed
c 5 0 00000f08 fp_ddr_mixed
w 096 00ff0000 0 fp_src_high
c 4 1 000005aa fp_out_rewrite
c 5 0 0000000f fp_ddr_rewrite
w 196 00000000 0 fp_src_slot1
c 4 1 000005aa fp_src_slot0_only
